/* design/lrelu_activate.sv */
`timescale 1ns/1ps

module lrelu_activate (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          clken,
  input  lrelu_pkg::beat_ctl_t                          mid_ctl,
  input  lrelu_pkg::mid_data_t                          mid_data,
  input  logic [lrelu_pkg::GROUPS-1:0][lrelu_pkg::COEF_W-1:0] mid_offset,
  output lrelu_pkg::beat_ctl_t                          m_ctl,
  output lrelu_pkg::out_data_t                          m_data
);
  import lrelu_pkg::*;

  // clamp a wide signed sum into the output word
  function automatic logic [OUT_W-1:0] saturate(input logic signed [SUM2_W-1:0] v);
    logic [OUT_W-1:0] res;
    if (v > SUM2_W'(OUT_MAX)) begin
      res = OUT_MAX;
    end else if (v < SUM2_W'(OUT_MIN)) begin
      res = OUT_MIN;
    end else begin
      res = OUT_W'(v);
    end
    return res;
  endfunction

  // slope per lane, alpha only for negative lrelu lanes
  logic signed [COEF_W-1:0]  slope    [GROUPS][UNITS];

  // cycle one registers
  beat_ctl_t                 ctl_q;
  logic signed [PROD2_W-1:0] prod_q   [GROUPS][UNITS];
  logic signed [COEF_W-1:0]  offset_q [GROUPS];

  // floored product plus group offset, before clamping
  logic signed [SUM2_W-1:0]  sum      [GROUPS][UNITS];

  always_comb begin
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        if (mid_ctl.user.is_lrelu && mid_data[g][u][MID_W-1]) begin
          slope[g][u] = LRELU_ALPHA;
        end else begin
          slope[g][u] = ONE_COEF;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctl_q <= '0;
      for (int g = 0; g < GROUPS; g++) begin
        offset_q[g] <= '0;
        for (int u = 0; u < UNITS; u++) begin
          prod_q[g][u] <= '0;
        end
      end
    end else if (clken) begin
      ctl_q <= mid_ctl;
      for (int g = 0; g < GROUPS; g++) begin
        offset_q[g] <= mid_offset[g];
        for (int u = 0; u < UNITS; u++) begin
          prod_q[g][u] <= PROD2_W'($signed(mid_data[g][u])) * PROD2_W'(slope[g][u]);
        end
      end
    end
  end

  // floor shift, then add offset with one bit of headroom
  always_comb begin
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        sum[g][u] = SUM2_W'($signed(prod_q[g][u][PROD2_W-1:FRAC_BITS])) +
                    SUM2_W'(offset_q[g]);
      end
    end
  end

  // cycle two, output registers
  always_ff @(posedge clk) begin
    if (reset) begin
      m_ctl  <= '0;
      m_data <= '0;
    end else if (clken) begin
      m_ctl <= ctl_q;
      for (int g = 0; g < GROUPS; g++) begin
        for (int u = 0; u < UNITS; u++) begin
          m_data[g][u] <= saturate(sum[g][u]);
        end
      end
    end
  end

endmodule

/* design/lrelu_config_decode.sv */
`timescale 1ns/1ps

module lrelu_config_decode (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     clken,
  input  lrelu_pkg::cfg_t                          cfg,
  output lrelu_pkg::coef_t [lrelu_pkg::GROUPS-1:0] coefs
);
  import lrelu_pkg::*;

  // one-hot write strobes, one bit per group and field
  logic [GROUPS-1:0] wr_scale;
  logic [GROUPS-1:0] wr_bias;
  logic [GROUPS-1:0] wr_offset;

  // selected group as a one-hot vector
  logic [GROUPS-1:0] group_sel;

  always_comb begin
    group_sel = '0;
    for (int g = 0; g < GROUPS; g++) begin
      if (cfg.group == GROUP_W'(g)) begin
        group_sel[g] = 1'b1;
      end
    end
  end

  // a stalled pipeline also blocks config
  always_comb begin
    wr_scale  = '0;
    wr_bias   = '0;
    wr_offset = '0;
    if (clken && cfg.valid) begin
      case (cfg.op)
        CFG_SCALE: begin
          wr_scale = group_sel;
        end
        CFG_BIAS: begin
          wr_bias = group_sel;
        end
        CFG_OFFSET: begin
          wr_offset = group_sel;
        end
        default: begin
          // opcode 3 is reserved and writes nothing
          wr_scale = '0;
        end
      endcase
    end
  end

  // coefficient register file
  // new values are seen by beats accepted on the following edge
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int g = 0; g < GROUPS; g++) begin
        coefs[g] <= COEF_DEFAULT;
      end
    end else begin
      for (int g = 0; g < GROUPS; g++) begin
        if (wr_scale[g]) begin
          coefs[g].scale <= cfg.data;
        end
        if (wr_bias[g]) begin
          coefs[g].bias <= cfg.data;
        end
        if (wr_offset[g]) begin
          coefs[g].offset <= cfg.data;
        end
      end
    end
  end

endmodule

/* design/lrelu_engine.sv */
`timescale 1ns/1ps

module lrelu_engine (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 clken,
  input  lrelu_pkg::beat_ctl_t s_ctl,
  input  lrelu_pkg::in_data_t  s_data,
  input  lrelu_pkg::cfg_t      cfg,
  output lrelu_pkg::beat_ctl_t m_ctl,
  output lrelu_pkg::out_data_t m_data
);
  import lrelu_pkg::*;

  // live coefficient file, sampled by stage one on acceptance
  coef_t [GROUPS-1:0]             coefs;

  // between the two arithmetic stages
  beat_ctl_t                      mid_ctl;
  mid_data_t                      mid_data;
  logic [GROUPS-1:0][COEF_W-1:0]  mid_offset;

  // config writes, one register per edge
  lrelu_config_decode i_config_decode (
    .clk   (clk),
    .reset (reset),
    .clken (clken),
    .cfg   (cfg),
    .coefs (coefs)
  );

  // data * A + B, two enabled cycles
  lrelu_scale_bias i_scale_bias (
    .clk        (clk),
    .reset      (reset),
    .clken      (clken),
    .s_ctl      (s_ctl),
    .s_data     (s_data),
    .coefs      (coefs),
    .mid_ctl    (mid_ctl),
    .mid_data   (mid_data),
    .mid_offset (mid_offset)
  );

  // result * C + D and clamp, two enabled cycles
  lrelu_activate i_activate (
    .clk        (clk),
    .reset      (reset),
    .clken      (clken),
    .mid_ctl    (mid_ctl),
    .mid_data   (mid_data),
    .mid_offset (mid_offset),
    .m_ctl      (m_ctl),
    .m_data     (m_data)
  );

endmodule

/* design/lrelu_pkg.sv */
package lrelu_pkg;

  // array geometry
  localparam int GROUPS  = 2;
  localparam int UNITS   = 4;
  localparam int GROUP_W = $clog2(GROUPS);

  // word widths, all signed two's complement
  localparam int ACC_W     = 16;
  localparam int COEF_W    = 16;
  localparam int FRAC_BITS = 8;
  localparam int OUT_W     = 8;
  localparam int TAG_W     = 4;

  // stage one result, floor(x*a) plus b needs one guard bit
  localparam int MID_W   = ACC_W + COEF_W - FRAC_BITS + 1;

  // full precision products and the widest sum before saturation
  localparam int PROD1_W = ACC_W + COEF_W;
  localparam int PROD2_W = MID_W + COEF_W;
  localparam int SUM2_W  = PROD2_W - FRAC_BITS + 1;

  // fixed point constants, Q8.8
  localparam logic signed [COEF_W-1:0] LRELU_ALPHA = 26;
  localparam logic signed [COEF_W-1:0] ONE_COEF    = 256;

  // output clamp range
  localparam logic signed [OUT_W-1:0]  OUT_MAX = 127;
  localparam logic signed [OUT_W-1:0]  OUT_MIN = -128;

  // config opcodes, one per coefficient kind
  typedef enum logic [1:0] {
    CFG_SCALE  = 2'd0,
    CFG_BIAS   = 2'd1,
    CFG_OFFSET = 2'd2
  } cfg_op_t;

  // one addressed config write
  typedef struct packed {
    logic                valid;
    cfg_op_t             op;
    logic [GROUP_W-1:0]  group;
    logic [COEF_W-1:0]   data;
  } cfg_t;

  // coefficients held for one group
  typedef struct packed {
    logic signed [COEF_W-1:0] scale;
    logic signed [COEF_W-1:0] bias;
    logic signed [COEF_W-1:0] offset;
  } coef_t;

  // identity transform, used after reset
  localparam coef_t COEF_DEFAULT = '{scale: ONE_COEF, bias: '0, offset: '0};

  // sideband carried unchanged from input to output
  typedef struct packed {
    logic             is_lrelu;
    logic [TAG_W-1:0] tag;
  } user_t;

  // control that travels beside each beat
  typedef struct packed {
    logic  valid;
    logic  last;
    user_t user;
  } beat_ctl_t;

  // beat payloads, indexed [group][unit]
  typedef logic [GROUPS-1:0][UNITS-1:0][ACC_W-1:0] in_data_t;
  typedef logic [GROUPS-1:0][UNITS-1:0][MID_W-1:0] mid_data_t;
  typedef logic [GROUPS-1:0][UNITS-1:0][OUT_W-1:0] out_data_t;

endpackage

/* design/lrelu_scale_bias.sv */
`timescale 1ns/1ps

module lrelu_scale_bias (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          clken,
  input  lrelu_pkg::beat_ctl_t                          s_ctl,
  input  lrelu_pkg::in_data_t                           s_data,
  input  lrelu_pkg::coef_t [lrelu_pkg::GROUPS-1:0]      coefs,
  output lrelu_pkg::beat_ctl_t                          mid_ctl,
  output lrelu_pkg::mid_data_t                          mid_data,
  output logic [lrelu_pkg::GROUPS-1:0][lrelu_pkg::COEF_W-1:0] mid_offset
);
  import lrelu_pkg::*;

  // cycle one, product plus the coefficients the beat was accepted with
  beat_ctl_t                 ctl_q;
  logic signed [PROD1_W-1:0] prod_q   [GROUPS][UNITS];
  logic signed [COEF_W-1:0]  bias_q   [GROUPS];
  logic signed [COEF_W-1:0]  offset_q [GROUPS];

  // cycle two input, floored product plus bias
  logic signed [MID_W-1:0]   mid_sum  [GROUPS][UNITS];

  always_ff @(posedge clk) begin
    if (reset) begin
      ctl_q <= '0;
      for (int g = 0; g < GROUPS; g++) begin
        bias_q[g]   <= '0;
        offset_q[g] <= '0;
        for (int u = 0; u < UNITS; u++) begin
          prod_q[g][u] <= '0;
        end
      end
    end else if (clken) begin
      ctl_q <= s_ctl;
      for (int g = 0; g < GROUPS; g++) begin
        bias_q[g]   <= coefs[g].bias;
        offset_q[g] <= coefs[g].offset;
        for (int u = 0; u < UNITS; u++) begin
          // full precision, no rounding yet
          prod_q[g][u] <= PROD1_W'($signed(s_data[g][u])) *
                          PROD1_W'($signed(coefs[g].scale));
        end
      end
    end
  end

  // dropping the low FRAC_BITS of a signed value floors it
  always_comb begin
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        mid_sum[g][u] = MID_W'($signed(prod_q[g][u][PROD1_W-1:FRAC_BITS])) +
                        MID_W'(bias_q[g]);
      end
    end
  end

  // cycle two
  always_ff @(posedge clk) begin
    if (reset) begin
      mid_ctl    <= '0;
      mid_data   <= '0;
      mid_offset <= '0;
    end else if (clken) begin
      mid_ctl <= ctl_q;
      for (int g = 0; g < GROUPS; g++) begin
        // offset rides along so activation uses the same config snapshot
        mid_offset[g] <= offset_q[g];
        for (int u = 0; u < UNITS; u++) begin
          mid_data[g][u] <= mid_sum[g][u];
        end
      end
    end
  end

endmodule

/* files.f */
design/lrelu_pkg.sv
design/lrelu_config_decode.sv
design/lrelu_scale_bias.sv
design/lrelu_activate.sv
design/lrelu_engine.sv
verif/lrelu_engine_checker.sv
verif/lrelu_engine_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f files.f --top-module lrelu_engine_tb || exit 1
out=$(./obj_dir/Vlrelu_engine_tb +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF '>>> PASS' && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

/* verif/lrelu_engine_checker.sv */
`timescale 1ns/1ps

module lrelu_engine_checker (
  input logic                 clk,
  input logic                 reset,
  input logic                 clken,
  input lrelu_pkg::beat_ctl_t s_ctl,
  input lrelu_pkg::beat_ctl_t m_ctl,
  input lrelu_pkg::out_data_t m_data
);
  import lrelu_pkg::*;

  // failed assertion count, read by the testbench at the end
  int unsigned fails = 0;

  // input control history, one slot per enabled edge of pipeline depth
  beat_ctl_t ctl_hist [4];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        ctl_hist[i] <= '0;
      end
    end else if (clken) begin
      ctl_hist[0] <= s_ctl;
      for (int i = 1; i < 4; i++) begin
        ctl_hist[i] <= ctl_hist[i-1];
      end
    end
  end

  no_valid_in_reset: assert property (@(posedge clk) reset |=> !m_ctl.valid)
    else begin
      $error("m_ctl.valid high after a reset edge");
      fails++;
    end

  // four enabled edges from input to output
  fixed_latency: assert property (@(posedge clk) disable iff (reset) m_ctl == ctl_hist[3])
    else begin
      $error("m_ctl does not match s_ctl from four enabled edges earlier");
      fails++;
    end

  stall_hold: assert property (@(posedge clk) disable iff (reset)
    !clken |=> ($stable(m_ctl) && $stable(m_data)))
    else begin
      $error("output changed across a stalled edge");
      fails++;
    end

endmodule

/* verif/lrelu_engine_tb.sv */
`timescale 1ns/1ps

module lrelu_engine_tb;
  import lrelu_pkg::*;

  logic      clk;
  logic      reset;
  logic      clken;
  beat_ctl_t s_ctl;
  in_data_t  s_data;
  cfg_t      cfg;
  beat_ctl_t m_ctl;
  out_data_t m_data;

  int seed = 4;
  int errors = 0;
  int beats_seen = 0;
  int tests_done = 0;

  // coefficient file as the model sees it
  longint scale_m  [GROUPS];
  longint bias_m   [GROUPS];
  longint offset_m [GROUPS];

  // expected beats in acceptance order
  beat_ctl_t exp_ctl_q  [$];
  out_data_t exp_data_q [$];

  lrelu_engine i_lrelu_engine (
    .clk    (clk),
    .reset  (reset),
    .clken  (clken),
    .s_ctl  (s_ctl),
    .s_data (s_data),
    .cfg    (cfg),
    .m_ctl  (m_ctl),
    .m_data (m_data)
  );

  bind lrelu_engine lrelu_engine_checker i_checker (
    .clk    (clk),
    .reset  (reset),
    .clken  (clken),
    .s_ctl  (s_ctl),
    .m_ctl  (m_ctl),
    .m_data (m_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // two floored multiply-adds with a slope pick between them and a clamp at the end
  function automatic logic [OUT_W-1:0] expect_lane(input longint x, input longint a,
                                                   input longint b, input longint d,
                                                   input logic lrelu);
    longint mid;
    longint slope;
    longint s;
    mid = ((x * a) >>> FRAC_BITS) + b;
    slope = (lrelu && mid < 0) ? longint'(LRELU_ALPHA) : longint'(ONE_COEF);
    s = ((mid * slope) >>> FRAC_BITS) + d;
    if (s > longint'(OUT_MAX)) begin
      s = longint'(OUT_MAX);
    end else if (s < longint'(OUT_MIN)) begin
      s = longint'(OUT_MIN);
    end
    return OUT_W'(s);
  endfunction

  function automatic in_data_t make_beat(input longint base, input longint step);
    in_data_t d;
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        d[g][u] = ACC_W'(base + step * (g * UNITS + u));
      end
    end
    return d;
  endfunction

  function automatic in_data_t random_beat(input int span);
    in_data_t d;
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        d[g][u] = ACC_W'($random(seed) % span);
      end
    end
    return d;
  endfunction

  task automatic drive_beat(input logic lrelu, input logic last, input logic [TAG_W-1:0] tag,
                            input in_data_t data);
    beat_ctl_t ctl;
    out_data_t exp;
    ctl = '{valid: 1'b1, last: last, user: '{is_lrelu: lrelu, tag: tag}};
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        exp[g][u] = expect_lane(longint'($signed(data[g][u])), scale_m[g], bias_m[g],
                                offset_m[g], lrelu);
      end
    end
    s_ctl  = ctl;
    s_data = data;
    exp_ctl_q.push_back(ctl);
    exp_data_q.push_back(exp);
  endtask

  task automatic send_beat(input logic lrelu, input logic last, input logic [TAG_W-1:0] tag,
                           input in_data_t data, input logic stall);
    int spins;
    @(negedge clk);
    cfg.valid = 1'b0;
    drive_beat(lrelu, last, tag, data);
    spins = 0;
    // beat held at the input through a few random stall cycles
    while (stall && spins < 6 && ($random(seed) % 3) == 0) begin
      clken = 1'b0;
      @(negedge clk);
      spins++;
    end
    clken = 1'b1;
  endtask

  task automatic update_model(input cfg_op_t op, input int grp, input longint val);
    case (op)
      CFG_SCALE: scale_m[grp] = val;
      CFG_BIAS: bias_m[grp] = val;
      default: offset_m[grp] = val;
    endcase
  endtask

  task automatic write_cfg(input cfg_op_t op, input int grp, input longint val);
    @(negedge clk);
    s_ctl.valid = 1'b0;
    clken = 1'b1;
    cfg = '{valid: 1'b1, op: op, group: GROUP_W'(grp), data: COEF_W'(val)};
    update_model(op, grp, val);
  endtask

  task automatic wait_drain(input logic stall);
    int waited;
    waited = 0;
    while (exp_ctl_q.size() != 0 && waited < 100) begin
      @(negedge clk);
      s_ctl.valid = 1'b0;
      cfg.valid   = 1'b0;
      clken = !stall || (($random(seed) % 3) != 0);
      waited++;
    end
    clken = 1'b1;
    if (exp_ctl_q.size() != 0) begin
      $display("timeout: %0d expected beats did not arrive", exp_ctl_q.size());
      errors++;
      exp_ctl_q.delete();
      exp_data_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    tests_done++;
    $display("test %0d %s finished, %0d beats checked, %0d errors", tests_done, name,
             beats_seen, errors);
  endtask

  // an output beat counts only on an enabled edge
  always @(posedge clk) begin
    beat_ctl_t ec;
    out_data_t ed;
    if (!reset && clken && m_ctl.valid) begin
      if (exp_ctl_q.size() == 0) begin
        $display("output beat with tag %0h arrived with nothing expected", m_ctl.user.tag);
        errors++;
      end else begin
        ec = exp_ctl_q.pop_front();
        ed = exp_data_q.pop_front();
        beats_seen++;
        data_ok: assert (m_data == ed) else begin
          $display("FAIL m_data got %h expected %h", m_data, ed);
          errors++;
        end
        last_ok: assert (m_ctl.last == ec.last) else begin
          $display("FAIL m_ctl.last got %h expected %h", m_ctl.last, ec.last);
          errors++;
        end
        user_ok: assert (m_ctl.user == ec.user) else begin
          $display("FAIL m_ctl.user got %h expected %h", m_ctl.user, ec.user);
          errors++;
        end
      end
    end
  end

  initial begin
    in_data_t data;
    clken  = 1'b1;
    reset  = 1'b1;
    // valid beats offered during reset must not reach the output
    s_ctl  = '{valid: 1'b1, last: 1'b1, user: '{is_lrelu: 1'b1, tag: 4'hf}};
    s_data = make_beat(100, 50);
    cfg    = '0;
    for (int g = 0; g < GROUPS; g++) begin
      scale_m[g]  = longint'(ONE_COEF);
      bias_m[g]   = 0;
      offset_m[g] = 0;
    end
    repeat (8) @(negedge clk);
    reset  = 1'b0;
    s_ctl  = '0;
    s_data = '0;

    // with identity coefficients only the clamp acts
    send_beat(1'b0, 1'b1, 4'h1, make_beat(-400, 110), 1'b0);
    wait_drain(1'b0);
    end_test("reset defaults");

    write_cfg(CFG_SCALE, 0, 384);
    write_cfg(CFG_BIAS, 0, -20);
    write_cfg(CFG_SCALE, 1, 64);
    write_cfg(CFG_BIAS, 1, 7);
    for (int i = 0; i < 3; i++) begin
      send_beat(1'b0, i == 2, TAG_W'(i), random_beat(150), 1'b0);
    end
    wait_drain(1'b0);
    end_test("per group scale and bias");

    write_cfg(CFG_OFFSET, 0, 10);
    write_cfg(CFG_OFFSET, 1, -5);
    send_beat(1'b1, 1'b0, 4'h3, make_beat(-300, 80), 1'b0);
    send_beat(1'b1, 1'b0, 4'h4, random_beat(2000), 1'b0);
    send_beat(1'b0, 1'b1, 4'h5, make_beat(-300, 80), 1'b0);
    wait_drain(1'b0);
    end_test("leaky slope and offset");

    // large scale drives both clamp limits
    write_cfg(CFG_SCALE, 0, 16384);
    write_cfg(CFG_SCALE, 1, 16384);
    send_beat(1'b0, 1'b0, 4'h8, make_beat(-30000, 8500), 1'b0);
    send_beat(1'b1, 1'b1, 4'h9, make_beat(-30000, 8500), 1'b0);
    wait_drain(1'b0);
    end_test("saturation");

    write_cfg(CFG_SCALE, 0, 100);
    write_cfg(CFG_SCALE, 1, -90);
    for (int i = 0; i < 20; i++) begin
      send_beat(1'($random(seed)), (i == 19) || 1'($random(seed)), TAG_W'(i),
                random_beat(1500), 1'b1);
    end
    wait_drain(1'b1);
    end_test("random burst with stalls");

    // a beat on the config edge keeps the old scale
    data = make_beat(-200, 60);
    @(negedge clk);
    clken = 1'b1;
    cfg = '{valid: 1'b1, op: CFG_SCALE, group: GROUP_W'(0), data: COEF_W'(512)};
    drive_beat(1'b0, 1'b0, 4'h6, data);
    update_model(CFG_SCALE, 0, 512);
    @(negedge clk);
    cfg.valid = 1'b0;
    drive_beat(1'b0, 1'b1, 4'h7, data);
    wait_drain(1'b0);
    end_test("config on the beat edge");

    $display("%0d tests, %0d beats checked, %0d errors, %0d checker failures", tests_done,
             beats_seen, errors, i_lrelu_engine.i_checker.fails);
    if (errors == 0 && i_lrelu_engine.i_checker.fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
